// ==== hdl/mul_pkg.sv ====
package mul_pkg;

    // word widths
    typedef logic signed [31:0] operand_t;  // operand / multiplicand
    typedef logic signed [63:0] product_t;  // full two's-complement product
    typedef logic [31:0]        half_t;     // one half of the product register

    // one Booth step per multiplier bit
    localparam int NUM_ITER = 32;

    // iteration counter width
    localparam int CNT_W = 6;

    // controller states
    // ACCUM never sits in the state register, it marks an EVAL cycle that writes
    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        EVAL,
        ACCUM,
        SHIFT,
        FINISH
    } booth_state_t;

endpackage

// ==== hdl/booth_datapath.sv ====
`timescale 1ns/100ps

module booth_datapath
    import mul_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  operand_t a,
    input  operand_t b,
    input  logic     load_ops,    // capture operands, clear accumulator
    input  logic     acc_en,      // write add/sub result to upper half
    input  logic     sub_sel,     // 1: subtract multiplicand
    input  logic     shift_en,    // arithmetic right shift by one
    output logic [1:0] booth_pair,
    output product_t product
);

    operand_t mcand_q;        // multiplicand
    half_t    acc_hi_q;       // accumulator, upper half of product
    half_t    mul_lo_q;       // multiplier, lower half of product
    logic     extra_bit_q;    // bit shifted out below bit 0
    logic     guard_bit_q;    // sign of the widened partial sum

    logic [32:0] addend;      // multiplicand or its one's complement, sign extended
    logic [32:0] sum_wide;    // 33-bit add/sub result

    // multiplicand only changes on load
    always_ff @(posedge clk) begin
        if (load_ops) begin
            mcand_q <= a;
        end
    end

    // single adder/subtractor
    // subtract by inverting the addend and feeding sub_sel as carry in
    always_comb begin
        addend   = {mcand_q[31], mcand_q} ^ {33{sub_sel}};
        sum_wide = {guard_bit_q, acc_hi_q} + addend + {32'd0, sub_sel};
    end

    // product register, extra bit and guard bit
    //
    // the upper half can grow by one bit during an accumulate (most negative
    // multiplicand).  guard_bit_q keeps that bit so the following shift
    // brings in the true sign.  after the shift the value fits 32 bits again,
    // so guard_bit_q then equals bit 63.
    always_ff @(posedge clk) begin
        if (rst) begin
            acc_hi_q    <= '0;
            mul_lo_q    <= '0;
            extra_bit_q <= 1'b0;
            guard_bit_q <= 1'b0;
        end else if (load_ops) begin
            acc_hi_q    <= '0;
            mul_lo_q    <= b;
            extra_bit_q <= 1'b0;
            guard_bit_q <= 1'b0;
        end else if (acc_en) begin
            acc_hi_q    <= sum_wide[31:0];
            guard_bit_q <= sum_wide[32];
        end else if (shift_en) begin
            acc_hi_q    <= {guard_bit_q, acc_hi_q[31:1]};  // sign extend
            mul_lo_q    <= {acc_hi_q[0], mul_lo_q[31:1]};
            extra_bit_q <= mul_lo_q[0];                  // old bit 0
        end
    end

    // recoding pair: 10 subtract, 01 add, 00/11 nothing
    assign booth_pair = {mul_lo_q[0], extra_bit_q};

    // register shown directly
    assign product = {acc_hi_q, mul_lo_q};

    // controller never asks for an accumulate and a shift in one cycle
    a_no_acc_and_shift: assert property (
        @(posedge clk) disable iff (rst)
        !(acc_en && shift_en)
    ) else $error("acc_en and shift_en high together");

endmodule

// ==== hdl/booth_ctrl.sv ====
`timescale 1ns/100ps

module booth_ctrl
    import mul_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  logic [1:0] booth_pair,
    output logic       load_ops,
    output logic       acc_en,
    output logic       sub_sel,
    output logic       shift_en,
    output logic       busy,
    output logic       done
);

    booth_state_t state_q;
    booth_state_t state_d;
    booth_state_t step;          // state_q with the accumulate cycle made visible

    logic [CNT_W-1:0] cnt_q;     // iterations left after the current one
    logic             accepted;  // start seen while not busy
    logic             need_write;

    // pair 01 or 10 means an add or a subtract
    assign need_write = booth_pair[1] ^ booth_pair[0];

    // accumulate folded into EVAL
    assign step = (state_q == EVAL && need_write) ? ACCUM : state_q;

    assign accepted = start && !busy;

    // state register
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (accepted) begin
                    state_d = LOAD;
                end
            end
            LOAD:  state_d = EVAL;
            EVAL:  state_d = SHIFT;
            SHIFT: begin
                if (cnt_q == '0) begin
                    state_d = FINISH;
                end else begin
                    state_d = EVAL;
                end
            end
            FINISH: begin
                // busy is already low here, so a start is taken
                if (accepted) begin
                    state_d = LOAD;
                end else begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    // iteration counter, counts down from NUM_ITER-1
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt_q <= '0;
        end else if (state_q == LOAD) begin
            cnt_q <= CNT_W'(NUM_ITER - 1);
        end else if (state_q == SHIFT && cnt_q != '0) begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    // strobes decoded from the step
    assign load_ops = (step == LOAD);
    assign acc_en   = (step == ACCUM);
    assign sub_sel  = (step == ACCUM) && (booth_pair == 2'b10);
    assign shift_en = (step == SHIFT);
    assign busy     = step inside {LOAD, EVAL, ACCUM, SHIFT};
    assign done     = (step == FINISH);

    // done is a single-cycle pulse
    a_done_pulse: assert property (
        @(posedge clk) disable iff (rst)
        done |=> !done
    ) else $error("done longer than one cycle");

    // busy drops in the done cycle
    a_done_busy: assert property (
        @(posedge clk) disable iff (rst)
        done |-> $fell(busy)
    ) else $error("done without busy falling");

    // a load only follows an accepted start
    a_load_after_start: assert property (
        @(posedge clk) disable iff (rst)
        load_ops |-> $past(accepted)
    ) else $error("load_ops without accepted start");

endmodule

// ==== hdl/booth_multiplier.sv ====
`timescale 1ns/100ps

module booth_multiplier
    import mul_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     start,    // one-cycle pulse
    input  operand_t a,        // multiplicand
    input  operand_t b,        // multiplier
    output product_t product,
    output logic     busy,
    output logic     done      // one-cycle pulse, product valid
);

    // controller to datapath
    logic load_ops;
    logic acc_en;
    logic sub_sel;
    logic shift_en;

    // datapath to controller
    logic [1:0] booth_pair;

    // sequencing
    booth_ctrl ctrl_i (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .booth_pair (booth_pair),
        .load_ops   (load_ops),
        .acc_en     (acc_en),
        .sub_sel    (sub_sel),
        .shift_en   (shift_en),
        .busy       (busy),
        .done       (done)
    );

    // registers and add/sub
    booth_datapath datapath_i (
        .clk        (clk),
        .rst        (rst),
        .a          (a),
        .b          (b),
        .load_ops   (load_ops),
        .acc_en     (acc_en),
        .sub_sel    (sub_sel),
        .shift_en   (shift_en),
        .booth_pair (booth_pair),
        .product    (product)
    );

endmodule

// ==== bench/booth_checker.sv ====
`timescale 1ns/100ps

module booth_checker
    import mul_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     start,
    input  operand_t a,
    input  operand_t b,
    input  logic     busy,
    input  logic     done,
    input  product_t product,
    input  logic     file_vec,    // expected value comes from the data file
    input  product_t file_exp,
    output int       test_count,
    output int       error_count
);

    localparam int LATENCY_CYCLES = 65;  // accepted start edge to done
    localparam int HOLD_CYCLES    = 10;  // idle cycles the result must survive

    logic     active    = 1'b0;  // a product is on its way
    logic     holding   = 1'b0;  // result must stay put
    logic     rst_q     = 1'b0;  // rst seen at the previous edge
    int       cyc       = 0;     // cycle index since the accepted start
    int       hold_cnt  = 0;
    int       err_mark  = 0;     // error count when the running test began
    int       hold_mark = 0;
    int       tests     = 0;
    int       errors    = 0;
    product_t exp_q     = '0;
    product_t hold_q    = '0;
    operand_t a_q       = '0;
    operand_t b_q       = '0;
    logic     src_q     = 1'b0;

    assign test_count  = tests;
    assign error_count = errors;

    // reference value, straight from the operands
    function automatic product_t full_product(input operand_t x, input operand_t y);
        product_t wx;
        product_t wy;
        wx = x;  // sign extends
        wy = y;
        return wx * wy;
    endfunction

    task automatic check_word(input string name, input product_t expected,
                              input product_t actual);
        if (actual !== expected) begin
            $display("FAIL t=%0t %s expected %h got %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("FAIL t=%0t %s expected %b got %b", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic close_test(input string what, input int mark);
        tests++;
        $display("test %0d: %s, %s", tests, what, (errors == mark) ? "ok" : "fail");
    endtask

    // all samples taken before the edge updates the DUT
    always @(posedge clk) begin
        if (rst_q) begin  // cycle right after a reset edge
            check_bit("busy", 1'b0, busy);
            check_bit("done", 1'b0, done);
            check_word("product", '0, product);
        end

        if (rst) begin
            if (active) begin
                close_test("computation cut short by reset", err_mark);
            end
            if (!rst_q) begin
                err_mark = errors;
            end
            active  = 1'b0;
            holding = 1'b0;
        end else begin
            if (rst_q) begin
                close_test("reset values", err_mark);
            end

            if (holding) begin
                check_word("product", hold_q, product);
                hold_cnt++;
                if (hold_cnt == HOLD_CYCLES) begin
                    close_test($sformatf("product %h held %0d idle cycles", hold_q,
                                         HOLD_CYCLES), hold_mark);
                end
            end

            if (active) begin
                if (done === 1'b1) begin
                    if (cyc != LATENCY_CYCLES) begin
                        $display("FAIL t=%0t done_latency expected %0d got %0d",
                                 $time, LATENCY_CYCLES, cyc);
                        errors++;
                    end
                    check_bit("busy", 1'b0, busy);  // busy falls with done
                    check_word("product", exp_q, product);
                    close_test($sformatf("%s %h * %h = %h", src_q ? "file" : "random",
                                         a_q, b_q, product), err_mark);
                    active    = 1'b0;
                    holding   = 1'b1;
                    hold_q    = product;
                    hold_cnt  = 0;
                    hold_mark = errors;
                end else begin
                    check_bit("busy", 1'b1, busy);
                    if (cyc == LATENCY_CYCLES) begin
                        $display("done missing %0d cycles after the start, t=%0t",
                                 LATENCY_CYCLES, $time);
                        errors++;
                    end
                    cyc++;
                end
            end else if (done !== 1'b0) begin
                $display("done high with no product pending, t=%0t", $time);
                errors++;
            end

            if (start === 1'b1 && busy === 1'b0) begin
                active   = 1'b1;
                holding  = 1'b0;
                cyc      = 0;
                err_mark = errors;
                a_q      = a;
                b_q      = b;
                src_q    = file_vec;
                exp_q    = file_vec ? file_exp : full_product(a, b);
            end
        end
        rst_q = rst;
    end

endmodule

// ==== bench/tb_booth_multiplier.sv ====
`timescale 1ns/100ps

module tb_booth_multiplier
    import mul_pkg::*;
();

    localparam string TESTDATA_FILE = "bench/mul_testdata.txt";
    localparam int    DONE_TIMEOUT  = 200;  // cycles per wait
    localparam int    RESET_CYCLES  = 8;

    logic     clk = 1'b0;
    logic     rst;
    logic     start;
    operand_t a;
    operand_t b;
    product_t product;
    logic     busy;
    logic     done;

    logic     file_vec;
    product_t file_exp;
    int       test_count;
    int       error_count;

    logic [31:0] lcg_state    = 32'hd509_9269;
    int          random_count = 0;
    bit          aborted      = 1'b0;  // timeout or unreadable data file

    always #50 clk = ~clk;  // 100 ns period

    booth_multiplier booth_multiplier_i (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .a       (a),
        .b       (b),
        .product (product),
        .busy    (busy),
        .done    (done)
    );

    booth_checker checker_i (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .a           (a),
        .b           (b),
        .busy        (busy),
        .done        (done),
        .product     (product),
        .file_vec    (file_vec),
        .file_exp    (file_exp),
        .test_count  (test_count),
        .error_count (error_count)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic idle(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic wait_done();
        int n;
        bit seen;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < DONE_TIMEOUT) begin
            @(negedge clk);
            seen = (done === 1'b1);
            n++;
        end
        if (!seen) begin
            $display("timeout: no done within %0d cycles, t=%0t", DONE_TIMEOUT, $time);
            aborted = 1'b1;
        end
    endtask

    // one-cycle start pulse, inputs change on the falling edge
    task automatic pulse_start(input operand_t va, input operand_t vb,
                               input logic from_file, input product_t exp_p);
        @(negedge clk);
        a        = va;
        b        = vb;
        file_vec = from_file;
        file_exp = exp_p;
        start    = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic multiply(input operand_t va, input operand_t vb,
                            input logic from_file, input product_t exp_p);
        pulse_start(va, vb, from_file, exp_p);
        wait_done();
        idle(2);
    endtask

    // lines: '#' comment, 'v a b product' in hex, 'r count' in decimal
    task automatic run_file_vectors();
        int       fd;
        int       c;
        int       n;
        operand_t va;
        operand_t vb;
        product_t vp;
        fd = $fopen(TESTDATA_FILE, "r");
        if (fd == 0) begin
            $display("cannot open %s", TESTDATA_FILE);
            aborted = 1'b1;
        end else begin
            c = $fgetc(fd);
            while (c != -1 && !aborted) begin
                if (c == "#") begin
                    while (c != -1 && c != "\n") begin
                        c = $fgetc(fd);
                    end
                end else if (c == "v") begin
                    n = $fscanf(fd, " %h %h %h", va, vb, vp);
                    if (n != 3) begin
                        $display("malformed vector line in %s", TESTDATA_FILE);
                        aborted = 1'b1;
                    end else begin
                        multiply(va, vb, 1'b1, vp);
                    end
                end else if (c == "r") begin
                    n = $fscanf(fd, " %d", random_count);
                end
                if (c != -1) begin
                    c = $fgetc(fd);
                end
            end
            $fclose(fd);
        end
    endtask

    // second start arrives mid-run and must change nothing
    task automatic start_while_busy();
        pulse_start(32'h0001_2345, 32'hffff_8001, 1'b0, '0);
        idle(10);
        pulse_start(32'h7fff_ffff, 32'h7fff_ffff, 1'b0, '0);
        wait_done();
        idle(2);
    endtask

    task automatic reset_mid_run();
        pulse_start(32'h0bad_cafe, 32'hf00d_0042, 1'b0, '0);
        idle(20);
        rst = 1'b1;
        idle(2);
        rst = 1'b0;
        idle(3);
        multiply(32'hffff_fff9, 32'h0000_0007, 1'b0, '0);  // normal run afterwards
    endtask

    initial begin
        operand_t ra;
        operand_t rb;
        int       i;
        rst      = 1'b1;
        start    = 1'b0;
        a        = '0;
        b        = '0;
        file_vec = 1'b0;
        file_exp = '0;
        idle(RESET_CYCLES);
        rst = 1'b0;
        idle(2);

        run_file_vectors();

        for (i = 0; i < random_count && !aborted; i++) begin
            lcg_state = lcg_next(lcg_state);
            ra        = lcg_state;
            lcg_state = lcg_next(lcg_state);
            rb        = lcg_state;
            multiply(ra, rb, 1'b0, '0);
        end

        if (!aborted) begin
            start_while_busy();
        end
        if (!aborted) begin
            pulse_start(32'h8000_0000, 32'h0000_0003, 1'b0, '0);
            wait_done();
            idle(12);  // result watched while idle
        end
        if (!aborted) begin
            reset_mid_run();
        end

        idle(2);
        $display("summary: %0d tests, %0d errors", test_count, error_count);
        if (!aborted && error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== bench/mul_testdata.txt ====
# v <operand a> <operand b> <expected 64-bit product>, all hex, two's complement
# r <number of random signed pairs>, decimal
v 00000000 00000000 0000000000000000
v 00000000 00000001 0000000000000000
v 00000001 00000000 0000000000000000
v 00000000 ffffffff 0000000000000000
v 80000000 00000000 0000000000000000
v 00000001 00000001 0000000000000001
v 00000001 ffffffff ffffffffffffffff
v ffffffff 00000001 ffffffffffffffff
v ffffffff ffffffff 0000000000000001
v 80000000 80000000 4000000000000000
v 80000000 ffffffff 0000000080000000
v ffffffff 80000000 0000000080000000
v 80000000 00000001 ffffffff80000000
v 00000001 80000000 ffffffff80000000
v 7fffffff 7fffffff 3fffffff00000001
v 7fffffff 80000000 c000000080000000
v 80000000 7fffffff c000000080000000
v 7fffffff ffffffff ffffffff80000001
v 7fffffff 00000001 000000007fffffff
v 00000002 00000003 0000000000000006
v fffffffe 00000003 fffffffffffffffa
v 00000002 fffffffd fffffffffffffffa
v fffffffe fffffffd 0000000000000006
v 0000000a fffffff6 ffffffffffffff9c
v 00010000 00010000 0000000100000000
v ffff0000 00010000 ffffffff00000000
v ffff0000 ffff0000 0000000100000000
v 00000100 00000100 0000000000010000
v 55555555 00000003 00000000ffffffff
v aaaaaaaa 00000001 ffffffffaaaaaaaa
v 55555555 ffffffff ffffffffaaaaaaab
v aaaaaaaa ffffffff 0000000055555556
v 55555555 55555555 1c71c71c38e38e39
v aaaaaaaa aaaaaaaa 1c71c71ce38e38e4
v 55555555 aaaaaaaa e38e38e371c71c72
v 0f0f0f0f 00000010 00000000f0f0f0f0
v f0f0f0f0 00000010 ffffffff0f0f0f00
v 12345678 00000001 0000000012345678
v 12345678 ffffffff ffffffffedcba988
v 00000003 7fffffff 000000017ffffffd
v fffffffd 80000000 0000000180000000
v 00001000 00001000 0000000001000000
v fffff000 00001000 ffffffffff000000
v 00000007 fffffff9 ffffffffffffffcf
v ffffffff 00000000 0000000000000000
r 32

// ==== vlog.f ====
hdl/mul_pkg.sv
hdl/booth_datapath.sv
hdl/booth_ctrl.sv
hdl/booth_multiplier.sv
bench/booth_checker.sv
bench/tb_booth_multiplier.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator, run it, then look for the pass line in sim.log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_booth_multiplier \
    -o tb_booth_multiplier \
    -f vlog.f > sim.log 2>&1 \
    && ./obj_dir/tb_booth_multiplier >> sim.log 2>&1

grep -qF "*** TEST PASSED ***" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }
